//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/ex_tb.sv
`timescale 1ns/10ps

module ex_tb;
    import ex_pkg::*;

    localparam int          N_INSTR     = 2000;
    localparam int          CYCLE_LIMIT = 4 * N_INSTR;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic        clk;
    logic        rst;
    ex_issue_t   issue_i;
    logic        advance_i;
    logic        flush_i;
    logic        clear_i;
    logic        dcache_ready_i;
    logic        llbit_i;
    logic        advance_ready_o;
    dcache_req_t dcache_req_o;
    redirect_t   redirect_o;
    ex_mem_t     ex_mem_o;

    logic [31:0] lfsr   = 32'd22;
    int          cycles = 0;

    ex_top u_dut (
        .clk             (clk),
        .rst             (rst),
        .issue_i         (issue_i),
        .advance_i       (advance_i),
        .flush_i         (flush_i),
        .clear_i         (clear_i),
        .dcache_ready_i  (dcache_ready_i),
        .llbit_i         (llbit_i),
        .advance_ready_o (advance_ready_o),
        .dcache_req_o    (dcache_req_o),
        .redirect_o      (redirect_o),
        .ex_mem_o        (ex_mem_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what);
        $display("CHECK FAILED at %0t: %s", $time, what);
        abort_run();
    endtask

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return bits;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic is_memory_access(input ex_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W,
                          OP_ST_B, OP_ST_H, OP_ST_W, OP_LL, OP_SC};
    endfunction

    function automatic logic is_control_transfer(input ex_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                          OP_B, OP_BL, OP_JIRL};
    endfunction

    function automatic logic [XLEN-1:0] compute_alu(input ex_issue_t in);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = in.oprand1;
        b = in.oprand2;
        case (in.op)
            OP_AND:       return a & b;
            OP_OR:        return a | b;
            OP_NOR:       return ~(a | b);
            OP_XOR:       return a ^ b;
            OP_SLL:       return a << b[4:0];
            OP_SRL:       return a >> b[4:0];
            OP_SRA:       return $unsigned($signed(a) >>> b[4:0]);
            OP_ADD:       return a + b;
            OP_SUB:       return a - b;
            OP_SLT:       return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU:      return {{(XLEN-1){1'b0}}, a < b};
            OP_LUI:       return b;
            OP_PCADDU12I: return in.pc + b;
            default:      return '0;
        endcase
    endfunction

    function automatic logic is_taken_branch(input ex_issue_t in);
        case (in.op)
            OP_BEQ:               return in.oprand1 == in.oprand2;
            OP_BNE:               return in.oprand1 != in.oprand2;
            OP_BLT:               return $signed(in.oprand1) < $signed(in.oprand2);
            OP_BGE:               return $signed(in.oprand1) >= $signed(in.oprand2);
            OP_BLTU:              return in.oprand1 < in.oprand2;
            OP_BGEU:              return in.oprand1 >= in.oprand2;
            OP_B, OP_BL, OP_JIRL: return 1'b1;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] target_of(input ex_issue_t in);
        return (in.op == OP_JIRL) ? in.oprand1 + in.imm : in.pc + in.imm;
    endfunction

    function automatic logic mispredicted(input ex_issue_t in, input logic taken);
        if (taken != in.predicted_taken) begin
            return 1'b1;
        end
        if (taken) begin
            return target_of(in) != in.predicted_next_pc;
        end
        return in.is_last_in_block && (in.pc + PC_STEP != in.predicted_next_pc);
    endfunction

    function automatic mem_size_e access_size(input ex_op_e op);
        case (op)
            OP_LD_B, OP_LD_BU, OP_ST_B: return MEM_BYTE;
            OP_LD_H, OP_LD_HU, OP_ST_H: return MEM_HALF;
            default:                    return MEM_WORD;
        endcase
    endfunction

    function automatic logic misaligned(input ex_op_e op, input logic [XLEN-1:0] addr);
        case (access_size(op))
            MEM_HALF: return addr[0];
            MEM_WORD: return addr[1:0] != 2'b00;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic dcache_req_t build_request(input ex_issue_t in,
                                                  input logic [XLEN-1:0] addr);
        dcache_req_t req;
        logic [1:0]  off;
        logic        store;
        off          = addr[1:0];
        store        = in.op inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
        req          = '0;
        req.ce       = 1'b1;
        req.we       = store;
        req.addr     = addr;
        req.req_type = access_size(in.op);
        case (req.req_type)
            MEM_BYTE: begin
                req.sel  = 4'b0001 << off;
                req.data = {24'h0, in.oprand2[7:0]} << (8 * off);
            end
            MEM_HALF: begin
                req.sel  = 4'b0011 << off;
                req.data = {16'h0, in.oprand2[15:0]} << (8 * off);
            end
            default: begin
                req.sel  = 4'b1111;
                req.data = in.oprand2;
            end
        endcase
        if (!store) begin
            req.data = '0;
        end
        return req;
    endfunction

    logic [XLEN-1:0] exp_addr;
    logic            exp_taken;
    logic            exp_mem_op;
    logic            exp_misaligned;
    logic            exp_ready;
    logic            exp_send;
    ex_mem_t         exp_mem;
    redirect_t       exp_redirect;
    dcache_req_t     exp_req;

    always_comb begin
        exp_addr       = issue_i.oprand1 + issue_i.imm;
        exp_taken      = is_taken_branch(issue_i);
        exp_mem_op     = issue_i.valid && is_memory_access(issue_i.op);
        exp_misaligned = misaligned(issue_i.op, exp_addr);
        exp_ready      = !(exp_mem_op && !dcache_ready_i);

        exp_mem          = '0;
        exp_mem.valid    = issue_i.valid;
        exp_mem.pc       = issue_i.pc;
        exp_mem.op       = issue_i.op;
        exp_mem.waddr    = issue_i.waddr;
        exp_mem.wreg     = issue_i.wreg;
        exp_mem.mem_addr = exp_addr;
        exp_mem.excp_ale = exp_mem_op && exp_misaligned;
        exp_mem.is_taken = issue_i.valid && exp_taken;
        if (issue_i.op == OP_BL || issue_i.op == OP_JIRL) begin
            exp_mem.wdata = issue_i.pc + PC_STEP;
        end else if (is_control_transfer(issue_i.op) || is_memory_access(issue_i.op)) begin
            exp_mem.wdata = '0;
        end else begin
            exp_mem.wdata = compute_alu(issue_i);
        end

        exp_redirect.valid  = advance_i && issue_i.valid && mispredicted(issue_i, exp_taken);
        exp_redirect.target = exp_taken ? target_of(issue_i) : issue_i.pc + PC_STEP;
        exp_redirect.pc     = issue_i.pc;

        // SC that lost its reservation never reaches the cache
        exp_send = advance_i && exp_mem_op && dcache_ready_i && !exp_misaligned &&
                   !(issue_i.op == OP_SC && !llbit_i);
        exp_req  = exp_send ? build_request(issue_i, exp_addr) : '0;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    request_matches: assert property (@(posedge clk) disable iff (rst)
        dcache_req_o == exp_req)
        else report_mismatch("dcache request differs from the model");

    redirect_matches: assert property (@(posedge clk) disable iff (rst)
        redirect_o == exp_redirect)
        else report_mismatch("redirect differs from the model");

    ready_matches: assert property (@(posedge clk) disable iff (rst)
        advance_ready_o == exp_ready)
        else report_mismatch("advance_ready_o differs from the model");

    advance_allowed: assert property (@(posedge clk) disable iff (rst)
        advance_i |-> advance_ready_o)
        else report_mismatch("advance given while the stage was not ready");

    record_loaded: assert property (@(posedge clk) disable iff (rst)
        (advance_i && !flush_i && !clear_i) |=> ex_mem_o == $past(exp_mem))
        else report_mismatch("stage record differs from the model after advance");

    record_held: assert property (@(posedge clk) disable iff (rst)
        (!advance_i && !flush_i && !clear_i) |=> ex_mem_o == $past(ex_mem_o))
        else report_mismatch("stage record changed without advance");

    record_flushed: assert property (@(posedge clk) disable iff (rst)
        (flush_i || clear_i) |=> ex_mem_o == '0)
        else report_mismatch("stage record not empty after flush or clear");

    reset_clears: assert property (@(posedge clk) rst |=> ex_mem_o == '0)
        else report_mismatch("stage record not empty after reset");

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic ex_issue_t make_issue();
        ex_issue_t   in;
        logic [5:0]  code;
        logic [11:0] imm12;
        logic [15:0] imm16;
        in                   = '0;
        code                 = 6'(take_bits(6) % 33);
        in.op                = ex_op_e'(code);
        in.valid             = take_bits(4) != 0;
        in.pc                = take_bits(28) << 2;
        in.oprand1           = take_bits(32);
        in.oprand2           = (take_bits(2) == 0) ? in.oprand1 : take_bits(32);
        in.waddr             = 5'(take_bits(5));
        in.wreg              = take_bits(1) != 0;
        in.is_last_in_block  = take_bits(1) != 0;
        in.predicted_next_pc = in.pc + PC_STEP;
        if (is_memory_access(in.op)) begin
            imm12  = 12'(take_bits(12));
            in.imm = {{20{imm12[11]}}, imm12};
            // Bias toward aligned addresses
            if (take_bits(1) != 0) begin
                in.oprand1[1:0] = 2'b00;
                in.imm[1:0]     = 2'b00;
            end
        end else if (is_control_transfer(in.op)) begin
            imm16              = 16'(take_bits(16));
            in.imm             = {{14{imm16[15]}}, imm16, 2'b00};
            in.predicted_taken = take_bits(1) != 0;
            case (take_bits(2))
                0, 1:    in.predicted_next_pc = target_of(in);
                2:       in.predicted_next_pc = in.pc + PC_STEP;
                default: in.predicted_next_pc = take_bits(32);
            endcase
        end else begin
            in.imm = take_bits(32);
        end
        return in;
    endfunction

    initial begin
        ex_issue_t next_issue;
        logic      dready;
        logic      adv;
        logic      need_issue;
        int        advanced;

        rst            = 1'b1;
        issue_i        = '0;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        clear_i        = 1'b0;
        dcache_ready_i = 1'b1;
        llbit_i        = 1'b0;
        next_issue     = '0;
        need_issue     = 1'b1;
        advanced       = 0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Issue stays put until the edge that advances it
        while (advanced < N_INSTR) begin
            if (need_issue) begin
                next_issue = make_issue();
                need_issue = 1'b0;
            end
            dready = take_bits(2) != 0;
            adv    = !(next_issue.valid && is_memory_access(next_issue.op) && !dready) &&
                     (take_bits(3) != 0);
            issue_i        <= next_issue;
            dcache_ready_i <= dready;
            advance_i      <= adv;
            llbit_i        <= take_bits(1) != 0;
            flush_i        <= take_bits(5) == 0;
            clear_i        <= take_bits(6) == 0;
            if (adv) begin
                need_issue = 1'b1;
                advanced++;
            end
            @(posedge clk);
        end

        advance_i <= 1'b0;
        flush_i   <= 1'b0;
        clear_i   <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

endmodule

//--- filelist.f
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_mem_req.sv
logic/ex_stage_reg.sv
logic/ex_top.sv
bench/ex_tb.sv

//--- logic/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
    input  ex_pkg::ex_issue_t       issue_i,
    output logic [ex_pkg::XLEN-1:0] alu_result_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    logic_out;
    logic [XLEN-1:0]    shift_out;
    logic [XLEN-1:0]    arith_out;
    logic [XLEN-1:0]    move_out;
    logic               signed_lt;
    logic               unsigned_lt;

    assign op1   = issue_i.oprand1;
    assign op2   = issue_i.oprand2;
    assign shamt = op2[SHAMT_W-1:0];

    assign signed_lt   = $signed(op1) < $signed(op2);
    assign unsigned_lt = op1 < op2;

    always_comb begin
        case (issue_i.op)
            OP_AND:  logic_out = op1 & op2;
            OP_OR:   logic_out = op1 | op2;
            OP_NOR:  logic_out = ~(op1 | op2);
            default: logic_out = op1 ^ op2;
        endcase
    end

    always_comb begin
        case (issue_i.op)
            OP_SLL:  shift_out = op1 << shamt;
            OP_SRL:  shift_out = op1 >> shamt;
            default: shift_out = $unsigned($signed(op1) >>> shamt);
        endcase
    end

    always_comb begin
        case (issue_i.op)
            OP_ADD:  arith_out = op1 + op2;
            OP_SUB:  arith_out = op1 - op2;
            OP_SLT:  arith_out = XLEN'(signed_lt);
            default: arith_out = XLEN'(unsigned_lt);
        endcase
    end

    // Upper immediate is already placed in oprand2 by decode
    assign move_out = (issue_i.op == OP_LUI) ? op2 : issue_i.pc + op2;

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb begin
        case (issue_i.op)
            OP_AND, OP_OR, OP_NOR, OP_XOR: alu_result_o = logic_out;
            OP_SLL, OP_SRL, OP_SRA:        alu_result_o = shift_out;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU: alu_result_o = arith_out;
            OP_LUI, OP_PCADDU12I:          alu_result_o = move_out;
            default:                       alu_result_o = '0;
        endcase
    end

    // Decode must never hand over an encoding past the last op
    always_comb begin
        if (issue_i.valid) begin
            assert (!$isunknown(issue_i.op) && issue_i.op <= OP_SC)
                else $error("ex_alu: unknown op %0d on a valid issue", issue_i.op);
        end
    end

endmodule

//--- logic/ex_branch.sv
`timescale 1ns/10ps

module ex_branch (
    input  logic                    advance_i,
    input  ex_pkg::ex_issue_t       issue_i,
    output logic                    branch_taken_o,
    output logic [ex_pkg::XLEN-1:0] link_result_o,
    output ex_pkg::redirect_t       redirect_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] fall_through;
    logic            taken;
    logic            dir_mispredict;
    logic            target_mispredict;

    assign fall_through = issue_i.pc + XLEN'(PC_STEP);

    // JIRL jumps off a register while the rest are pc relative
    assign jump_target = (issue_i.op == OP_JIRL) ? issue_i.oprand1 + issue_i.imm
                                                 : issue_i.pc + issue_i.imm;

    always_comb begin
        case (issue_i.op)
            OP_BEQ:  taken = issue_i.oprand1 == issue_i.oprand2;
            OP_BNE:  taken = issue_i.oprand1 != issue_i.oprand2;
            OP_BLT:  taken = $signed(issue_i.oprand1) < $signed(issue_i.oprand2);
            OP_BGE:  taken = $signed(issue_i.oprand1) >= $signed(issue_i.oprand2);
            OP_BLTU: taken = issue_i.oprand1 < issue_i.oprand2;
            OP_BGEU: taken = issue_i.oprand1 >= issue_i.oprand2;
            OP_B, OP_BL, OP_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign branch_taken_o = issue_i.valid & taken;
    assign link_result_o  = fall_through;

    //////////////////////////////////////////////////
    // Misprediction
    //////////////////////////////////////////////////

    assign dir_mispredict = taken ^ issue_i.predicted_taken;

    // Wrong target, or a block end whose fall through was not predicted
    assign target_mispredict =
        (taken & issue_i.predicted_taken & (jump_target != issue_i.predicted_next_pc)) |
        (~taken & ~issue_i.predicted_taken & issue_i.is_last_in_block &
         (fall_through != issue_i.predicted_next_pc));

    assign redirect_o.valid  = advance_i & issue_i.valid &
                               (dir_mispredict | target_mispredict);
    assign redirect_o.target = taken ? jump_target : fall_through;
    assign redirect_o.pc     = issue_i.pc;

endmodule

//--- logic/ex_mem_req.sv
`timescale 1ns/10ps

module ex_mem_req (
    input  ex_pkg::ex_issue_t       issue_i,
    input  logic                    advance_i,
    input  logic                    dcache_ready_i,
    input  logic                    llbit_i,
    output logic [ex_pkg::XLEN-1:0] mem_addr_o,
    output logic                    excp_ale_o,
    output logic                    is_mem_o,
    output ex_pkg::dcache_req_t     dcache_req_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]     addr;
    logic [OFFSET_W-1:0] offset;
    mem_size_e           size;
    logic                is_store;
    logic                misaligned;
    logic                sc_blocked;
    logic                ce;

    assign addr   = issue_i.oprand1 + issue_i.imm;
    assign offset = addr[OFFSET_W-1:0];

    always_comb begin
        case (issue_i.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: size = MEM_BYTE;
            OP_LD_H, OP_LD_HU, OP_ST_H: size = MEM_HALF;
            default:                    size = MEM_WORD;
        endcase
    end

    assign is_store = issue_i.op inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};

    always_comb begin
        case (size)
            MEM_HALF: misaligned = addr[0];
            MEM_WORD: misaligned = |offset;
            default:  misaligned = 1'b0;
        endcase
    end

    // SC without the LL reservation completes without touching memory
    assign sc_blocked = (issue_i.op == OP_SC) & ~llbit_i;

    assign is_mem_o   = issue_i.valid & is_mem_op(issue_i.op);
    assign excp_ale_o = is_mem_o & misaligned;
    assign mem_addr_o = addr;

    assign ce = advance_i & is_mem_o & dcache_ready_i & ~misaligned & ~sc_blocked;

    //////////////////////////////////////////////////
    // Data cache request
    //////////////////////////////////////////////////

    always_comb begin
        dcache_req_o = '0;
        if (ce) begin
            dcache_req_o.ce       = 1'b1;
            dcache_req_o.we       = is_store;
            dcache_req_o.req_type = size;
            dcache_req_o.addr     = addr;
            case (size)
                MEM_BYTE: begin
                    dcache_req_o.sel = BYTE_LANES'(1) << offset;
                    dcache_req_o.data = XLEN'(issue_i.oprand2[7:0]) << {offset, 3'b000};
                end
                MEM_HALF: begin
                    dcache_req_o.sel = BYTE_LANES'(3) << offset;
                    dcache_req_o.data = XLEN'(issue_i.oprand2[15:0]) << {offset, 3'b000};
                end
                default: begin
                    dcache_req_o.sel  = '1;
                    dcache_req_o.data = issue_i.oprand2;
                end
            endcase
            // Loads carry no write data
            if (!is_store) begin
                dcache_req_o.data = '0;
            end
        end
    end

endmodule

//--- logic/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_LANES = XLEN / 8;
    localparam int PC_STEP    = XLEN / 8;
    localparam int OFFSET_W   = $clog2(BYTE_LANES);
    localparam int SHAMT_W    = $clog2(XLEN);

    //////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_LUI, OP_PCADDU12I,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_B, OP_BL, OP_JIRL,
        OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W,
        OP_ST_B, OP_ST_H, OP_ST_W,
        OP_LL, OP_SC
    } ex_op_e;

    // Data cache request type
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    //////////////////////////////////////////////////
    // Stage records
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        ex_op_e                op;
        logic [XLEN-1:0]       oprand1;
        logic [XLEN-1:0]       oprand2;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] waddr;
        logic                  wreg;
        logic                  predicted_taken;
        logic                  is_last_in_block;
        logic [XLEN-1:0]       predicted_next_pc;
    } ex_issue_t;

    typedef struct packed {
        logic                  ce;
        logic                  we;
        mem_size_e             req_type;
        logic [BYTE_LANES-1:0] sel;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       data;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        ex_op_e                op;
        logic [REG_ADDR_W-1:0] waddr;
        logic                  wreg;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       mem_addr;
        logic                  excp_ale;
        logic                  is_taken;
    } ex_mem_t;

    function automatic logic is_branch_op(ex_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                          OP_B, OP_BL, OP_JIRL};
    endfunction

    function automatic logic is_mem_op(ex_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W,
                          OP_ST_B, OP_ST_H, OP_ST_W, OP_LL, OP_SC};
    endfunction

endpackage

//--- logic/ex_stage_reg.sv
`timescale 1ns/10ps

module ex_stage_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance_i,
    input  logic            flush_i,
    input  logic            clear_i,
    input  ex_pkg::ex_mem_t d_i,
    output ex_pkg::ex_mem_t q_o
);
    import ex_pkg::*;

    ex_mem_t q;

    // Flush and clear win over a simultaneous advance
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (flush_i || clear_i) begin
            q <= '0;
        end else if (advance_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- logic/ex_top.sv
`timescale 1ns/10ps

module ex_top (
    input  logic                clk,
    input  logic                rst,
    input  ex_pkg::ex_issue_t   issue_i,
    input  logic                advance_i,
    input  logic                flush_i,
    input  logic                clear_i,
    input  logic                dcache_ready_i,
    input  logic                llbit_i,
    output logic                advance_ready_o,
    output ex_pkg::dcache_req_t dcache_req_o,
    output ex_pkg::redirect_t   redirect_o,
    output ex_pkg::ex_mem_t     ex_mem_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] link_result;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] wdata;
    logic            branch_taken;
    logic            excp_ale;
    logic            is_mem;
    ex_mem_t         ex_mem;

    ex_alu u_alu (
        .issue_i      (issue_i),
        .alu_result_o (alu_result)
    );

    ex_branch u_branch (
        .advance_i      (advance_i),
        .issue_i        (issue_i),
        .branch_taken_o (branch_taken),
        .link_result_o  (link_result),
        .redirect_o     (redirect_o)
    );

    ex_mem_req u_mem_req (
        .issue_i        (issue_i),
        .advance_i      (advance_i),
        .dcache_ready_i (dcache_ready_i),
        .llbit_i        (llbit_i),
        .mem_addr_o     (mem_addr),
        .excp_ale_o     (excp_ale),
        .is_mem_o       (is_mem),
        .dcache_req_o   (dcache_req_o)
    );

    //////////////////////////////////////////////////
    // Write back and stage record
    //////////////////////////////////////////////////

    always_comb begin
        if (issue_i.op == OP_BL || issue_i.op == OP_JIRL) begin
            wdata = link_result;
        end else if (is_branch_op(issue_i.op) || is_mem_op(issue_i.op)) begin
            wdata = '0;
        end else begin
            wdata = alu_result;
        end
    end

    assign ex_mem.valid    = issue_i.valid;
    assign ex_mem.pc       = issue_i.pc;
    assign ex_mem.op       = issue_i.op;
    assign ex_mem.waddr    = issue_i.waddr;
    assign ex_mem.wreg     = issue_i.wreg;
    assign ex_mem.wdata    = wdata;
    assign ex_mem.mem_addr = mem_addr;
    assign ex_mem.excp_ale = excp_ale;
    assign ex_mem.is_taken = branch_taken;

    // Hold off only while a memory op waits for the cache
    assign advance_ready_o = ~(is_mem & ~dcache_ready_i);

    ex_stage_reg u_stage_reg (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance_i),
        .flush_i   (flush_i),
        .clear_i   (clear_i),
        .d_i       (ex_mem),
        .q_o       (ex_mem_o)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Controller withholds advance while the cache is busy
    advance_waits_for_cache: assert property (@(posedge clk) disable iff (rst)
        (advance_i && is_mem) |-> dcache_ready_i)
        else $error("ex_top: memory op advanced while the cache was busy");

    // Dispatch holds the issue until it leaves the stage
    issue_held: assert property (@(posedge clk)
        (!rst && !advance_i && !flush_i && !clear_i) |=> $stable(issue_i))
        else $error("ex_top: issue changed before it advanced");

endmodule
